/* design/nx_consts.svh */
// Width and depth constants for the logic node
// Shared by the RTL and the testbench, include wherever a width is needed

`ifndef NX_CONSTS_SVH
`define NX_CONSTS_SVH

// ------------------------------
// Message stream
// ------------------------------

`define NX_STREAM_WIDTH 32
`define NX_ROW_WIDTH    4
`define NX_COL_WIDTH    4

// ------------------------------
// Instruction store
// ------------------------------

`define NX_INSTR_WIDTH  15
`define NX_MAX_INSTRS   16
// One bit wider than the address so a full store can be counted
`define NX_COUNT_WIDTH  5

// ------------------------------
// Logic state
// ------------------------------

`define NX_INPUTS       8
`define NX_OUTPUTS      8
`define NX_REGISTERS    8

`endif

/* design/nx_msg_pkg.sv */
// Message types for the inbound stream of the node
// Both views of a message word share the command and address fields
// at the top of the word, only the payload differs

`include "nx_consts.svh"

package nx_msg_pkg;

    // Command in bits 31:30
    typedef enum logic [1:0] {
        NX_CMD_LOAD   = 2'd0,
        NX_CMD_SIGNAL = 2'd1,
        NX_CMD_CLEAR  = 2'd2,
        NX_CMD_RSVD   = 2'd3
    } nx_command_t;

    // Load instruction view
    typedef struct packed {
        nx_command_t                command;
        logic [`NX_ROW_WIDTH-1:0]   row;
        logic [`NX_COL_WIDTH-1:0]   col;
        logic [`NX_STREAM_WIDTH-`NX_ROW_WIDTH-`NX_COL_WIDTH-`NX_INSTR_WIDTH-3:0] padding;
        logic [`NX_INSTR_WIDTH-1:0] instr;
    } nx_msg_load_t;

    // Signal state view, index in 3:1 and state in bit 0
    typedef struct packed {
        nx_command_t                    command;
        logic [`NX_ROW_WIDTH-1:0]       row;
        logic [`NX_COL_WIDTH-1:0]       col;
        logic [`NX_STREAM_WIDTH-`NX_ROW_WIDTH-`NX_COL_WIDTH-$clog2(`NX_INPUTS)-4:0] padding;
        logic [$clog2(`NX_INPUTS)-1:0]  index;
        logic                           state;
    } nx_msg_signal_t;

    // One word, decoded either way
    typedef union packed {
        nx_msg_load_t   load;
        nx_msg_signal_t signal;
    } nx_msg_t;

endpackage : nx_msg_pkg

/* design/nx_instr_pkg.sv */
// Instruction types for the node core
// An instruction combines two operands with a boolean op and writes the
// result to a working register, and to an output when flagged

`include "nx_consts.svh"

package nx_instr_pkg;

    // Boolean operations
    typedef enum logic [2:0] {
        NX_OP_AND   = 3'd0,
        NX_OP_OR    = 3'd1,
        NX_OP_XOR   = 3'd2,
        NX_OP_NAND  = 3'd3,
        NX_OP_NOR   = 3'd4,
        NX_OP_XNOR  = 3'd5,
        NX_OP_NOT_A = 3'd6,
        NX_OP_MOV_A = 3'd7
    } nx_opcode_t;

    // Sources use the top bit to pick a register over an input
    typedef struct packed {
        nx_opcode_t                        opcode;
        logic [$clog2(`NX_REGISTERS):0]    src_a;
        logic [$clog2(`NX_REGISTERS):0]    src_b;
        logic [$clog2(`NX_REGISTERS)-1:0]  target;
        logic                              is_output;
    } nx_instr_t;

endpackage : nx_instr_pkg

/* design/nx_msg_decoder.sv */
// Inbound message decoder for the node
// Accepts one word per cycle while the core is idle, drops anything not
// addressed to this node, and turns the rest into one-cycle strobes for
// the instruction store and the core

`timescale 1ns/1ps

`include "nx_consts.svh"

module nx_msg_decoder (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    // Inbound stream
    , input  logic [`NX_STREAM_WIDTH-1:0]   msg_data_i
    , input  logic                          msg_valid_i
    , output logic                          msg_ready_o
    // Own address
    , input  logic [`NX_ROW_WIDTH-1:0]      node_row_i
    , input  logic [`NX_COL_WIDTH-1:0]      node_col_i
    , input  logic                          core_idle_i
    // Store strobes
    , output nx_instr_pkg::nx_instr_t       instr_data_o
    , output logic                          instr_valid_o
    , output logic                          clear_valid_o
    // Input signal update
    , output logic [$clog2(`NX_INPUTS)-1:0] signal_index_o
    , output logic                          signal_state_o
    , output logic                          signal_valid_o
    , output logic                          pending_o
);

    import nx_msg_pkg::*;
    import nx_instr_pkg::*;

    nx_msg_t                       msg;
    logic                          accept;
    logic                          match;
    nx_instr_t                     instr_q;
    logic                          instr_valid_q;
    logic                          clear_valid_q;
    logic                          signal_valid_q;
    logic [$clog2(`NX_INPUTS)-1:0] signal_index_q;
    logic                          signal_state_q;

    // Back-pressure only while a program runs
    assign msg_ready_o = core_idle_i;
    assign accept      = msg_valid_i && msg_ready_o;

    // Address fields sit at the same bits in both views
    assign msg   = msg_data_i;
    assign match = (msg.load.row == node_row_i) && (msg.load.col == node_col_i);

    // ------------------------------
    // Strobes
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_valid_q  <= 1'b0;
            clear_valid_q  <= 1'b0;
            signal_valid_q <= 1'b0;
        end else begin
            // Reserved commands fall through all three
            instr_valid_q  <= accept && match && (msg.load.command == NX_CMD_LOAD);
            signal_valid_q <= accept && match && (msg.load.command == NX_CMD_SIGNAL);
            clear_valid_q  <= accept && match && (msg.load.command == NX_CMD_CLEAR);
        end
    end

    // Payload, only meaningful alongside a strobe
    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q        <= nx_instr_t'(msg.load.instr);
            signal_index_q <= msg.signal.index;
            signal_state_q <= msg.signal.state;
        end
    end

    assign instr_data_o   = instr_q;
    assign instr_valid_o  = instr_valid_q;
    assign clear_valid_o  = clear_valid_q;
    assign signal_index_o = signal_index_q;
    assign signal_state_o = signal_state_q;
    assign signal_valid_o = signal_valid_q;

    // Something still to land in store or core
    assign pending_o = instr_valid_q || clear_valid_q || signal_valid_q;

endmodule : nx_msg_decoder

/* design/nx_node_store.sv */
// Instruction store for the node
// Loads append at the populated count, a clear only rewinds the count.
// The core reads through a synchronous port, data one cycle after the read

`timescale 1ns/1ps

`include "nx_consts.svh"

module nx_node_store (
      input  logic                               clk_i
    , input  logic                               rst_n_i
    // Load side
    , input  nx_instr_pkg::nx_instr_t            store_data_i
    , input  logic                               store_valid_i
    , input  logic                               clear_i
    // Fetch side
    , input  logic [$clog2(`NX_MAX_INSTRS)-1:0]  fetch_addr_i
    , input  logic                               fetch_rd_i
    , output logic [`NX_COUNT_WIDTH-1:0]         instr_count_o
    , output nx_instr_pkg::nx_instr_t            fetch_data_o
);

    import nx_instr_pkg::*;

    nx_instr_t                  mem [`NX_MAX_INSTRS];
    nx_instr_t                  fetch_q;
    logic [`NX_COUNT_WIDTH-1:0] count_q;
    logic                       full;
    logic                       write;

    assign full  = (count_q == `NX_COUNT_WIDTH'(`NX_MAX_INSTRS));
    // Loads past the end are dropped
    assign write = store_valid_i && !full && !clear_i;

    // Populated count
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (write) begin
            count_q <= count_q + 1'b1;
        end
    end

    // ------------------------------
    // Memory
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (write) begin
            mem[count_q[$clog2(`NX_MAX_INSTRS)-1:0]] <= store_data_i;
        end
    end

    // Registered read
    always_ff @(posedge clk_i) begin
        if (fetch_rd_i) begin
            fetch_q <= mem[fetch_addr_i];
        end
    end

    assign instr_count_o = count_q;
    assign fetch_data_o  = fetch_q;

endmodule : nx_node_store

/* design/nx_node_core.sv */
// Execution core of the node
// Holds inputs, working registers and outputs, all kept across runs.
// A trigger walks the stored program once, with one fetch and one retire
// in flight per cycle, so results of one instruction reach the next

`timescale 1ns/1ps

`include "nx_consts.svh"

module nx_node_core (
      input  logic                               clk_i
    , input  logic                               rst_n_i
    // Execution control
    , input  logic                               trigger_i
    , input  logic [`NX_COUNT_WIDTH-1:0]         populated_i
    , output logic                               idle_o
    // Input signal update
    , input  logic [$clog2(`NX_INPUTS)-1:0]      signal_index_i
    , input  logic                               signal_state_i
    , input  logic                               signal_valid_i
    // Simulated logic outputs
    , output logic [`NX_OUTPUTS-1:0]             outputs_o
    // Instruction fetch
    , output logic [$clog2(`NX_MAX_INSTRS)-1:0]  instr_addr_o
    , output logic                               instr_rd_o
    , input  nx_instr_pkg::nx_instr_t            instr_data_i
);

    import nx_instr_pkg::*;

    logic                       busy_q;
    logic                       retire_q;
    logic [`NX_COUNT_WIDTH-1:0] pc_q;
    logic                       start;
    logic [`NX_INPUTS-1:0]      inputs_q;
    logic [`NX_REGISTERS-1:0]   regs_q;
    logic [`NX_OUTPUTS-1:0]     outputs_q;
    logic                       opnd_a;
    logic                       opnd_b;
    logic                       result;

    // Top bit picks the register file
    function automatic logic select_operand(
        input logic [$clog2(`NX_REGISTERS):0] src,
        input logic [`NX_INPUTS-1:0]          inputs,
        input logic [`NX_REGISTERS-1:0]       regs
    );
        logic [$clog2(`NX_REGISTERS)-1:0] idx;
        idx = src[$clog2(`NX_REGISTERS)-1:0];
        return src[$clog2(`NX_REGISTERS)] ? regs[idx] : inputs[idx];
    endfunction

    // ------------------------------
    // Sequencing
    // ------------------------------

    // Empty store or busy core ignores the trigger
    assign start        = !busy_q && trigger_i && (populated_i != '0);
    assign instr_rd_o   = busy_q && (pc_q < populated_i);
    assign instr_addr_o = pc_q[$clog2(`NX_MAX_INSTRS)-1:0];
    assign idle_o       = !busy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            retire_q <= 1'b0;
            pc_q     <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            pc_q   <= '0;
        end else if (busy_q) begin
            // Stays busy for the final retire, then drops
            busy_q   <= instr_rd_o;
            retire_q <= instr_rd_o;
            if (instr_rd_o) begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end

    // ------------------------------
    // Execute
    // ------------------------------

    always_comb begin
        opnd_a = select_operand(instr_data_i.src_a, inputs_q, regs_q);
        opnd_b = select_operand(instr_data_i.src_b, inputs_q, regs_q);
        result = 1'b0;
        case (instr_data_i.opcode)
            NX_OP_AND:   result = opnd_a & opnd_b;
            NX_OP_OR:    result = opnd_a | opnd_b;
            NX_OP_XOR:   result = opnd_a ^ opnd_b;
            NX_OP_NAND:  result = !(opnd_a & opnd_b);
            NX_OP_NOR:   result = !(opnd_a | opnd_b);
            NX_OP_XNOR:  result = !(opnd_a ^ opnd_b);
            NX_OP_NOT_A: result = !opnd_a;
            NX_OP_MOV_A: result = opnd_a;
        endcase
    end

    // Logic state, persists between runs
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inputs_q  <= '0;
            regs_q    <= '0;
            outputs_q <= '0;
        end else begin
            if (signal_valid_i) begin
                inputs_q[signal_index_i] <= signal_state_i;
            end
            if (retire_q) begin
                regs_q[instr_data_i.target] <= result;
                // Flagged results also drive the matching output
                if (instr_data_i.is_output) begin
                    outputs_q[instr_data_i.target] <= result;
                end
            end
        end
    end

    assign outputs_o = outputs_q;

endmodule : nx_node_core

/* design/nx_node.sv */
// Top level of a single logic node
// Messages on the inbound stream load the program and set inputs, a
// trigger runs the program, and idle rises again when the run is done

`timescale 1ns/1ps

`include "nx_consts.svh"

module nx_node (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    // Inbound message stream
    , input  logic [`NX_STREAM_WIDTH-1:0]   msg_data_i
    , input  logic                          msg_valid_i
    , output logic                          msg_ready_o
    // Node position in the grid
    , input  logic [`NX_ROW_WIDTH-1:0]      node_row_i
    , input  logic [`NX_COL_WIDTH-1:0]      node_col_i
    // Execution
    , input  logic                          trigger_i
    , output logic [`NX_OUTPUTS-1:0]        outputs_o
    , output logic                          idle_o
);

    import nx_instr_pkg::*;

    nx_instr_t                           instr_data;
    logic                                instr_valid;
    logic                                clear_valid;
    logic [$clog2(`NX_INPUTS)-1:0]       signal_index;
    logic                                signal_state;
    logic                                signal_valid;
    logic                                dcd_pending;
    logic [`NX_COUNT_WIDTH-1:0]          instr_count;
    nx_instr_t                           fetch_data;
    logic [$clog2(`NX_MAX_INSTRS)-1:0]   fetch_addr;
    logic                                fetch_rd;
    logic                                core_idle;
    logic                                idle_q;

    // ------------------------------
    // Idle
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idle_q <= 1'b0;
        end else begin
            idle_q <= core_idle && !dcd_pending;
        end
    end

    assign idle_o = idle_q;

    // ------------------------------
    // Blocks
    // ------------------------------

    nx_msg_decoder i_decoder (
          .clk_i         (clk_i       )
        , .rst_n_i       (rst_n_i     )
        , .msg_data_i    (msg_data_i  )
        , .msg_valid_i   (msg_valid_i )
        , .msg_ready_o   (msg_ready_o )
        , .node_row_i    (node_row_i  )
        , .node_col_i    (node_col_i  )
        , .core_idle_i   (core_idle   )
        , .instr_data_o  (instr_data  )
        , .instr_valid_o (instr_valid )
        , .clear_valid_o (clear_valid )
        , .signal_index_o(signal_index)
        , .signal_state_o(signal_state)
        , .signal_valid_o(signal_valid)
        , .pending_o     (dcd_pending )
    );

    nx_node_store i_store (
          .clk_i        (clk_i      )
        , .rst_n_i      (rst_n_i    )
        , .store_data_i (instr_data )
        , .store_valid_i(instr_valid)
        , .clear_i      (clear_valid)
        , .fetch_addr_i (fetch_addr )
        , .fetch_rd_i   (fetch_rd   )
        , .instr_count_o(instr_count)
        , .fetch_data_o (fetch_data )
    );

    nx_node_core i_core (
          .clk_i         (clk_i       )
        , .rst_n_i       (rst_n_i     )
        , .trigger_i     (trigger_i   )
        , .populated_i   (instr_count )
        , .idle_o        (core_idle   )
        , .signal_index_i(signal_index)
        , .signal_state_i(signal_state)
        , .signal_valid_i(signal_valid)
        , .outputs_o     (outputs_o   )
        , .instr_addr_o  (fetch_addr  )
        , .instr_rd_o    (fetch_rd    )
        , .instr_data_i  (fetch_data  )
    );

endmodule : nx_node

/* testbench/nx_node_checker.sv */
// Protocol assertions for the logic node
// Bound into every nx_node instance
// Watches the handshake, the decoder strobes and idle

`timescale 1ns/1ps

module nx_node_checker (
      input  logic       clk_i
    , input  logic       rst_n_i
    , input  logic       msg_valid_i
    , input  logic       msg_ready_i
    , input  logic       core_idle_i
    , input  logic       fetch_rd_i
    , input  logic       instr_valid_i
    , input  logic       clear_valid_i
    , input  logic       signal_valid_i
    , input  logic       trigger_i
    , input  logic [4:0] instr_count_i
    , input  logic       idle_i
    , input  logic [7:0] outputs_i
);

    // No message taken while the core fetches instructions
    ready_low_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_rd_i |-> !msg_ready_i) else $error("msg_ready_o high while core busy");

    // One strobe cycle per accepted word
    strobe_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i || clear_valid_i || signal_valid_i |-> $past(msg_valid_i && msg_ready_i))
        else $error("decoder strobe without an accepted word");

    // Outputs only move during a run
    outputs_stable_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(idle_i) && idle_i |-> $stable(outputs_i)) else $error("outputs_o moved while idle");

    // Core busy on the next edge and idle_o low one edge later
    trigger_starts_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_idle_i && trigger_i && (instr_count_i != 0) |=> !core_idle_i ##1 !idle_i)
        else $error("idle did not fall after an accepted trigger");

endmodule : nx_node_checker

bind nx_node nx_node_checker i_checker (
      .clk_i         (clk_i       )
    , .rst_n_i       (rst_n_i     )
    , .msg_valid_i   (msg_valid_i )
    , .msg_ready_i   (msg_ready_o )
    , .core_idle_i   (core_idle   )
    , .fetch_rd_i    (fetch_rd    )
    , .instr_valid_i (instr_valid )
    , .clear_valid_i (clear_valid )
    , .signal_valid_i(signal_valid)
    , .trigger_i     (trigger_i   )
    , .instr_count_i (instr_count )
    , .idle_i        (idle_o      )
    , .outputs_i     (outputs_o   )
);

/* testbench/tb_nx_node.sv */
// Testbench for the logic node
// Loads programs over the message stream, runs them and compares outputs
// against a behavioral model of the instruction rules

`timescale 1ns/1ps

`include "nx_consts.svh"

module tb_nx_node;

    import nx_msg_pkg::*;
    import nx_instr_pkg::*;

    localparam logic [3:0] ROW     = 4'd3;
    localparam logic [3:0] COL     = 4'd5;
    localparam int         TIMEOUT = 200;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] msg_data_i;
    logic        msg_valid_i;
    logic        msg_ready_o;
    logic [3:0]  node_row_i;
    logic [3:0]  node_col_i;
    logic        trigger_i;
    logic [7:0]  outputs_o;
    logic        idle_o;

    nx_instr_t  prog [`NX_MAX_INSTRS];
    int         prog_len;
    logic [7:0] exp_inputs;
    logic [7:0] exp_regs;
    logic [7:0] exp_outputs;
    integer     seed = 32'h0a0f5691;
    int         errors;
    int         tests_passed;
    int         tests_failed;
    int         checks_done;
    int         stall_cycles;
    event       check_ev;

    nx_node i_nx_node (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Reference model of one run that returns {regs, outputs}
    function automatic logic [15:0] run_model(input nx_instr_t p [`NX_MAX_INSTRS], input int n,
                                              input logic [7:0] ins, input logic [7:0] regs,
                                              input logic [7:0] outs);
        logic a;
        logic b;
        logic r;
        for (int i = 0; i < n; i++) begin
            a = p[i].src_a[3] ? regs[p[i].src_a[2:0]] : ins[p[i].src_a[2:0]];
            b = p[i].src_b[3] ? regs[p[i].src_b[2:0]] : ins[p[i].src_b[2:0]];
            r = 1'b0;
            case (p[i].opcode)
                NX_OP_AND:   r = a & b;
                NX_OP_OR:    r = a | b;
                NX_OP_XOR:   r = a ^ b;
                NX_OP_NAND:  r = ~(a & b);
                NX_OP_NOR:   r = ~(a | b);
                NX_OP_XNOR:  r = ~(a ^ b);
                NX_OP_NOT_A: r = ~a;
                NX_OP_MOV_A: r = a;
            endcase
            regs[p[i].target] = r;
            if (p[i].is_output) outs[p[i].target] = r;
        end
        return {regs, outs};
    endfunction

    function automatic logic [31:0] make_msg(input nx_command_t cmd, input logic [3:0] row,
                                             input logic [3:0] col, input logic [14:0] payload);
        nx_msg_t m;
        m              = '0;
        m.load.command = cmd;
        m.load.row     = row;
        m.load.col     = col;
        m.load.instr   = payload;
        return m;
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // ------------------------------
    // Stream and run helpers
    // ------------------------------

    task automatic send_word(input logic [31:0] w);
        int n;
        n = 0;
        @(posedge clk_i);
        msg_data_i  <= w;
        msg_valid_i <= 1'b1;
        @(negedge clk_i);
        while (!msg_ready_o) begin
            stall_cycles++;
            n++;
            if (n > TIMEOUT) abort_run("msg_ready_o never rose");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        msg_valid_i <= 1'b0;
    endtask

    task automatic set_input(input int idx, input logic val);
        send_word(make_msg(NX_CMD_SIGNAL, ROW, COL, 15'({idx[2:0], val})));
        exp_inputs[idx] = val;
    endtask

    // Foreign or reserved words that the node must drop
    task automatic send_noise(input int k);
        case (k % 4)
            0: send_word(make_msg(NX_CMD_LOAD, ROW, COL + 4'd1, 15'($random(seed))));
            1: send_word(make_msg(NX_CMD_RSVD, ROW, COL, 15'($random(seed))));
            2: send_word(make_msg(NX_CMD_CLEAR, ROW + 4'd1, COL, 15'd0));
            default: send_word(make_msg(NX_CMD_SIGNAL, ROW - 4'd1, COL, 15'h1));
        endcase
    endtask

    task automatic load_program(input bit noisy);
        send_word(make_msg(NX_CMD_CLEAR, ROW, COL, 15'd0));
        for (int i = 0; i < prog_len; i++) begin
            if (noisy) send_noise(i);
            send_word(make_msg(NX_CMD_LOAD, ROW, COL, prog[i]));
        end
    endtask

    task automatic wait_idle(input logic level);
        int n;
        n = 0;
        @(negedge clk_i);
        while (idle_o != level) begin
            n++;
            if (n > TIMEOUT) abort_run("idle_o did not reach expected level");
            @(negedge clk_i);
        end
    endtask

    task automatic pulse_trigger();
        @(posedge clk_i);
        trigger_i <= 1'b1;
        @(posedge clk_i);
        trigger_i <= 1'b0;
    endtask

    task automatic run_program();
        wait_idle(1'b1);
        pulse_trigger();
        wait_idle(1'b0);
        wait_idle(1'b1);
    endtask

    task automatic check_outputs();
        int target;
        int n;
        target = checks_done + 1;
        n = 0;
        -> check_ev;
        while (checks_done != target) begin
            n++;
            if (n > TIMEOUT) abort_run("compare process did not respond");
            #1;
        end
    endtask

    task automatic run_and_check();
        run_program();
        {exp_regs, exp_outputs} = run_model(prog, prog_len, exp_inputs, exp_regs, exp_outputs);
        check_outputs();
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", num, name);
        end
    endtask

    // Compare process
    initial begin
        forever begin
            @(check_ev);
            assert (outputs_o == exp_outputs) else begin
                $display("[ERROR] outputs_o got %h expected %h", outputs_o, exp_outputs);
                errors++;
            end
            checks_done++;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int e;
        logic [7:0] ins_before;
        rst_n_i     = 1'b0;
        msg_data_i  = '0;
        msg_valid_i = 1'b0;
        trigger_i   = 1'b0;
        node_row_i  = ROW;
        node_col_i  = COL;
        exp_inputs  = '0;
        exp_regs    = '0;
        exp_outputs = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Empty store ignores trigger
        e = errors;
        wait_idle(1'b1);
        pulse_trigger();
        repeat (10) begin
            @(negedge clk_i);
            assert (idle_o) else begin
                $display("idle_o fell after a trigger with an empty store");
                errors++;
            end
            assert (outputs_o == 8'h00) else begin
                $display("[ERROR] outputs_o got %h expected %h", outputs_o, 8'h00);
                errors++;
            end
        end
        check_outputs();
        finish_test(1, "reset and empty trigger", e);

        // One instruction per opcode reading inputs and registers
        e = errors;
        prog_len = 8;
        for (int i = 0; i < 8; i++) begin
            prog[i] = {3'(i), 4'(i), 4'(8 + (i + 1) % 8), 3'(i), 1'b1};
        end
        load_program(1'b0);
        for (int i = 0; i < 8; i++) set_input(i, (i % 3) == 0);
        run_and_check();
        finish_test(2, "fixed program", e);

        // Random programs with state carried across runs
        e = errors;
        for (int r = 0; r < 6; r++) begin
            prog_len = 1 + ({$random(seed)} % 16);
            for (int i = 0; i < prog_len; i++) prog[i] = nx_instr_t'(15'($random(seed)));
            load_program(1'b0);
            set_input({$random(seed)} % 8, 1'($random(seed)));
            set_input({$random(seed)} % 8, 1'($random(seed)));
            run_and_check();
        end
        finish_test(3, "random programs", e);

        // Dropped words interleaved with valid ones
        e = errors;
        prog_len = 10;
        for (int i = 0; i < prog_len; i++) prog[i] = nx_instr_t'(15'($random(seed)));
        load_program(1'b1);
        run_and_check();
        finish_test(4, "foreign and reserved words", e);

        // Clear, new program, and a message held off during the run
        e = errors;
        prog_len = 12;
        for (int i = 0; i < prog_len; i++) prog[i] = nx_instr_t'(15'($random(seed)));
        load_program(1'b0);
        ins_before = exp_inputs;
        stall_cycles = 0;
        fork
            run_program();
            begin
                int n;
                n = 0;
                @(negedge clk_i);
                while (msg_ready_o) begin
                    n++;
                    if (n > TIMEOUT) abort_run("msg_ready_o never fell during run");
                    @(negedge clk_i);
                end
                set_input(0, ~exp_inputs[0]);
            end
        join
        {exp_regs, exp_outputs} = run_model(prog, prog_len, ins_before, exp_regs, exp_outputs);
        check_outputs();
        assert (stall_cycles > 0) else begin
            $display("Message was accepted without waiting for the run to end");
            errors++;
        end
        run_and_check();
        finish_test(5, "clear and back-pressure", e);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_nx_node

/* sources.f */
+incdir+design
design/nx_msg_pkg.sv
design/nx_instr_pkg.sv
design/nx_msg_decoder.sv
design/nx_node_store.sv
design/nx_node_core.sv
design/nx_node.sv
testbench/nx_node_checker.sv
testbench/tb_nx_node.sv

/* Makefile */
# Verilator build and run for the logic node testbench
# Override any variable on the command line, e.g. make LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_nx_node
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
